// File: filelist.f
logic/usb_rx_pkg.sv
logic/flex_counter.sv
logic/rx_timer.sv
logic/rx_decoder.sv
logic/rx_byte_assembler.sv
logic/rx_fifo.sv
logic/usb_rx_wb.sv
logic/usb_rx_top.sv
tests/usb_rx_props.sv
tests/usb_rx_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = usb_rx_tb
FILELIST  = filelist.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "test passed" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tests/usb_rx_tb.sv
// Directed testbench for the USB full-speed receive path with line driver and bus tasks
`timescale 1ns/1ps

module usb_rx_tb import usb_rx_pkg::*; ();

  logic       clk;
  logic       n_rst;
  logic       d_plus;
  logic       d_minus;
  wb_req_t    wb_req;
  wb_rsp_t    wb_rsp;

  int         errors;
  int         checks;
  int         case_start;
  int         bit_phase;   // Bit lengths run 8, 8, 9 clocks
  int         ones_run;
  logic       line_j;      // Current line level is J
  logic [7:0] tx_bytes[$];
  rx_entry_t  exp_q[$];

  usb_rx_top dut_i (
    .clk    (clk),
    .n_rst  (n_rst),
    .d_plus (d_plus),
    .d_minus(d_minus),
    .wb_req (wb_req),
    .wb_rsp (wb_rsp)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic check_entry(input string name, input rx_entry_t want, input rx_entry_t got);
    checks++;
    if (got.kind != want.kind) begin
      errors++;
      $display("ERR %0t %s.kind exp %0d act %0d", $time, name, want.kind, got.kind);
    end
    if (got.sop != want.sop) begin
      errors++;
      $display("ERR %0t %s.sop exp %0b act %0b", $time, name, want.sop, got.sop);
    end
    if (got.data != want.data) begin
      errors++;
      $display("ERR %0t %s.data exp %02h act %02h", $time, name, want.data, got.data);
    end
  endtask

  task automatic check_status(input logic [fifo_aw:0] want_count, input logic want_ovf,
                              input logic [fifo_aw:0] got_count, input logic got_ovf);
    checks++;
    if (got_count != want_count) begin
      errors++;
      $display("ERR %0t count exp %0d act %0d", $time, want_count, got_count);
    end
    if (got_ovf != want_ovf) begin
      errors++;
      $display("ERR %0t overflow exp %0b act %0b", $time, want_ovf, got_ovf);
    end
  endtask

  // Master holds the request through the ack cycle and releases it after
  task automatic bus_access(input logic we, input logic [1:0] adr, input logic [31:0] wdat,
                            output logic [31:0] rdat);
    int   waited;
    logic got;
    waited = 0;
    got    = 1'b0;
    rdat   = '0;
    wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
    while (!got && waited < 20) begin
      @(posedge clk);
      #1;
      waited++;
      if (wb_rsp.ack) begin
        got  = 1'b1;
        rdat = wb_rsp.dat;
      end
    end
    if (!got) begin
      errors++;
      $display("Wishbone access to address %0d got no ack within 20 cycles", adr);
    end
    @(posedge clk);
    #2;
    wb_req = '0;
  endtask

  task automatic wb_read(input logic [1:0] adr, output logic [31:0] rdat);
    bus_access(1'b0, adr, 32'h0, rdat);
  endtask

  task automatic wb_write(input logic [1:0] adr, input logic [31:0] wdat);
    logic [31:0] unused;
    bus_access(1'b1, adr, wdat, unused);
  endtask

  task automatic read_entry(output rx_entry_t e);
    logic [31:0] w;
    wb_read(reg_data, w);
    e.kind = entry_kind_t'(w[10:9]);
    e.sop  = w[8];
    e.data = w[7:0];
  endtask

  task automatic read_status(output logic [fifo_aw:0] cnt, output logic ovf);
    logic [31:0] w;
    wb_read(reg_status, w);
    cnt = w[fifo_aw:0];
    ovf = w[8];
  endtask

  task automatic wait_count(input int n);
    int               tries;
    logic [fifo_aw:0] cnt;
    logic             ovf;
    tries = 0;
    cnt   = '0;
    while (cnt != n && tries < 40) begin
      read_status(cnt, ovf);
      tries++;
    end
    if (cnt != n) begin
      errors++;
      $display("FIFO never reached %0d entries, stuck at %0d", n, cnt);
    end
  endtask

  task automatic expect_next(input string name);
    rx_entry_t want;
    rx_entry_t got;
    want = '{kind: kind_empty, sop: 1'b0, data: 8'h00};
    if (exp_q.size() != 0) begin
      want = exp_q.pop_front();
    end
    read_entry(got);
    check_entry(name, want, got);
  endtask

  task automatic drain_expected();
    while (exp_q.size() != 0) begin
      expect_next("entry");
    end
    expect_next("empty_entry");  // FIFO must be empty now
  endtask

  task automatic expect_packet(input logic good);
    rx_entry_t e;
    for (int i = 0; i < tx_bytes.size(); i++) begin
      e.kind = kind_data;
      e.sop  = (i == 0);
      e.data = tx_bytes[i];
      exp_q.push_back(e);
    end
    if (good) begin
      e = '{kind: kind_end, sop: 1'b0, data: 8'h00};
      exp_q.push_back(e);
    end
  endtask

  task automatic fill_random(input int n);
    tx_bytes.delete();
    repeat (n) tx_bytes.push_back(8'($urandom));
  endtask

  task automatic drive_bit(input logic dp, input logic dm);
    int len;
    len       = (bit_phase == 2) ? 9 : 8;
    bit_phase = (bit_phase + 1) % 3;
    d_plus    = dp;
    d_minus   = dm;
    repeat (len) @(posedge clk);
    #2;
  endtask

  // A zero toggles the line and six ones in a row get a stuffed zero
  task automatic send_nrzi(input logic b, input logic stuff_on);
    if (!b) line_j = !line_j;
    drive_bit(line_j, !line_j);
    ones_run = b ? ones_run + 1 : 0;
    if (stuff_on && ones_run == 6) begin
      line_j = !line_j;
      drive_bit(line_j, !line_j);
      ones_run = 0;
    end
  endtask

  task automatic send_idle(input int n);
    line_j = 1'b1;
    repeat (n) drive_bit(1'b1, 1'b0);
  endtask

  task automatic send_packet(input int nostuff_from, input int lead_idle);
    send_idle(lead_idle);
    ones_run = 0;
    for (int i = 0; i < 8; i++) begin
      send_nrzi(i == 7, 1'b1);  // SYNC
    end
    for (int n = 0; n < tx_bytes.size(); n++) begin
      for (int i = 0; i < 8; i++) begin
        send_nrzi(tx_bytes[n][i], n < nostuff_from);
      end
    end
    drive_bit(1'b0, 1'b0);
    drive_bit(1'b0, 1'b0);
    send_idle(1);
  endtask

  task automatic begin_case();
    case_start = errors;
  endtask

  task automatic end_case(input int num, input string name);
    $display("case %0d %s: %s (%0d errors)", num, name,
             (errors == case_start) ? "ok" : "mismatch", errors - case_start);
  endtask

  task automatic check_reset_state();
    logic [fifo_aw:0] cnt;
    logic             ovf;
    read_status(cnt, ovf);
    check_status(0, 1'b0, cnt, ovf);
    expect_next("empty_entry");
    read_status(cnt, ovf);
    check_status(0, 1'b0, cnt, ovf);
  endtask

  task automatic receive_random_packet();
    fill_random(5);
    expect_packet(1'b1);
    send_packet(99, 4);
    wait_count(6);
    drain_expected();
  endtask

  task automatic receive_stuffed_bytes();
    tx_bytes = {8'hff, 8'hff, 8'h7e};
    expect_packet(1'b1);
    send_packet(99, 4);
    wait_count(4);
    drain_expected();
  endtask

  task automatic detect_stuff_error();
    rx_entry_t e;
    tx_bytes = {8'hff, 8'hff};
    e = '{kind: kind_data, sop: 1'b1, data: 8'hff};
    exp_q.push_back(e);
    e = '{kind: kind_err, sop: 1'b0, data: 8'h00};
    exp_q.push_back(e);
    send_packet(1, 4);
    wait_count(2);
    drain_expected();
  endtask

  task automatic fill_to_overflow();
    logic [fifo_aw:0] cnt;
    logic             ovf;
    fill_random(20);
    expect_packet(1'b1);
    while (exp_q.size() > fifo_depth) void'(exp_q.pop_back());  // Later pushes are dropped
    send_packet(99, 4);
    wait_count(fifo_depth);
    send_idle(2);
    read_status(cnt, ovf);
    check_status(16, 1'b1, cnt, ovf);
    wb_write(reg_data, 32'h1ff);  // Neither pops nor clears overflow
    read_status(cnt, ovf);
    check_status(16, 1'b1, cnt, ovf);
    drain_expected();
    read_status(cnt, ovf);
    check_status(0, 1'b1, cnt, ovf);
    wb_write(reg_status, 32'h100);
    read_status(cnt, ovf);
    check_status(0, 1'b0, cnt, ovf);
  endtask

  task automatic receive_back_to_back();
    fill_random(3);
    expect_packet(1'b1);
    send_packet(99, 4);
    fill_random(4);
    expect_packet(1'b1);
    fork
      send_packet(99, 3);
      begin
        wait_count(4);
        expect_next("between_entry");  // Read in the idle gap before the second SYNC
      end
    join
    wait_count(8);
    drain_expected();
  endtask

  initial begin
    void'($urandom(32'h37fc1815));
    errors    = 0;
    checks    = 0;
    bit_phase = 0;
    ones_run  = 0;
    line_j    = 1'b1;
    n_rst     = 1'b0;
    d_plus    = 1'b1;  // Idle J
    d_minus   = 1'b0;
    wb_req    = '0;
    repeat (4) @(posedge clk);
    #2;
    n_rst = 1'b1;
    repeat (2) @(posedge clk);
    #2;

    begin_case();
    check_reset_state();
    end_case(1, "reset state");
    begin_case();
    receive_random_packet();
    end_case(2, "random packet");
    begin_case();
    receive_stuffed_bytes();
    end_case(3, "stuffed bytes");
    begin_case();
    detect_stuff_error();
    end_case(4, "stuff error");
    begin_case();
    fill_to_overflow();
    end_case(5, "overflow");
    begin_case();
    receive_back_to_back();
    end_case(6, "back to back");

    $display("cases 6, checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// File: tests/usb_rx_props.sv
// Concurrent assertions on the Wishbone handshake and the mid-bit sample strobe
`timescale 1ns/1ps

module usb_rx_props import usb_rx_pkg::*; (
  input logic         clk,
  input logic         n_rst,
  input wb_req_t      wb_req,
  input wb_rsp_t      wb_rsp,
  input line_sample_t line
);

  ack_in_cycle: assert property (@(posedge clk) disable iff (!n_rst)
    wb_rsp.ack |-> (wb_req.cyc && wb_req.stb))
    else $error("ack seen outside an active bus cycle");

  ack_single: assert property (@(posedge clk) disable iff (!n_rst)
    wb_rsp.ack |=> !wb_rsp.ack)
    else $error("ack held for two cycles");

  strobe_single: assert property (@(posedge clk) disable iff (!n_rst)
    line.strobe |=> !line.strobe)  // Mid-bit pulse is one clock wide
    else $error("sample strobe high in two consecutive cycles");

endmodule

bind usb_rx_top usb_rx_props props_i (
  .clk   (clk),
  .n_rst (n_rst),
  .wb_req(wb_req),
  .wb_rsp(wb_rsp),
  .line  (line)
);

// File: logic/usb_rx_top.sv
// USB full-speed receive path top level chaining timer, decoder, assembler, FIFO and bus slave
`timescale 1ns/1ps

module usb_rx_top import usb_rx_pkg::*; (
  input  logic    clk,
  input  logic    n_rst,
  input  logic    d_plus,
  input  logic    d_minus,
  input  wb_req_t wb_req,
  output wb_rsp_t wb_rsp
);

  line_sample_t     line;
  dec_bit_t         dbit;
  rx_entry_t        entry;
  rx_entry_t        head;
  logic             push;
  logic             pop;
  logic             clear_overflow;
  logic             overflow;
  logic [fifo_aw:0] count;

  rx_timer timer_i (
    .clk    (clk),
    .n_rst  (n_rst),
    .d_plus (d_plus),
    .d_minus(d_minus),
    .line   (line)
  );

  rx_decoder decoder_i (
    .clk  (clk),
    .n_rst(n_rst),
    .line (line),
    .dbit (dbit)
  );

  rx_byte_assembler assembler_i (
    .clk  (clk),
    .n_rst(n_rst),
    .dbit (dbit),
    .entry(entry),
    .push (push)
  );

  rx_fifo fifo_i (
    .clk           (clk),
    .n_rst         (n_rst),
    .push          (push),
    .pop           (pop),
    .clear_overflow(clear_overflow),
    .wr_entry      (entry),
    .head          (head),
    .count         (count),
    .overflow      (overflow)
  );

  usb_rx_wb wb_i (
    .clk           (clk),
    .n_rst         (n_rst),
    .req           (wb_req),
    .rsp           (wb_rsp),
    .head          (head),
    .count         (count),
    .overflow      (overflow),
    .pop           (pop),
    .clear_overflow(clear_overflow)
  );

endmodule

// File: logic/usb_rx_wb.sv
// Wishbone classic slave with data pop register and status register
`timescale 1ns/1ps

module usb_rx_wb import usb_rx_pkg::*; (
  input  logic             clk,
  input  logic             n_rst,
  input  wb_req_t          req,
  output wb_rsp_t          rsp,
  input  rx_entry_t        head,
  input  logic [fifo_aw:0] count,
  input  logic             overflow,
  output logic             pop,
  output logic             clear_overflow
);

  logic        ack;
  logic [31:0] rd_data;

  // Single-cycle ack, one clock after cyc and stb are first seen
  always_ff @(posedge clk, negedge n_rst) begin
    if (!n_rst) begin
      ack <= 1'b0;
    end else begin
      ack <= req.cyc && req.stb && !ack;
    end
  end

  always_comb begin
    rd_data = '0;
    case (req.adr)
      reg_data:   rd_data = {21'b0, head};
      reg_status: rd_data = {23'b0, overflow, 3'b0, count};
      default:    rd_data = '0;
    endcase
  end

  // Head is stable through the ack cycle, the pop lands after it
  assign pop = ack && !req.we && (req.adr == reg_data) && (head.kind != kind_empty);
  assign clear_overflow = ack && req.we && (req.adr == reg_status) && req.dat[8];

  assign rsp.ack = ack;
  assign rsp.dat = rd_data;

endmodule

// File: logic/rx_fifo.sv
// 16-entry receive FIFO of tagged entries with sticky overflow flag
`timescale 1ns/1ps

module rx_fifo import usb_rx_pkg::*; (
  input  logic             clk,
  input  logic             n_rst,
  input  logic             push,
  input  logic             pop,
  input  logic             clear_overflow,
  input  rx_entry_t        wr_entry,
  output rx_entry_t        head,
  output logic [fifo_aw:0] count,
  output logic             overflow
);

  rx_entry_t            mem [fifo_depth];
  logic [fifo_aw-1:0]   wr_ptr;
  logic [fifo_aw-1:0]   rd_ptr;
  logic                 full;
  logic                 do_push;
  logic                 do_pop;

  assign full    = (count == (fifo_aw + 1)'(fifo_depth));
  assign do_push = push && !full;
  assign do_pop  = pop && (count != '0);

  always_ff @(posedge clk, negedge n_rst) begin
    if (!n_rst) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      overflow <= 1'b0;
    end else begin
      if (do_push) wr_ptr <= wr_ptr + 1'b1;
      if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
      count <= count + (fifo_aw + 1)'(do_push) - (fifo_aw + 1)'(do_pop);
      if (push && full) begin
        overflow <= 1'b1;  // Set wins over clear
      end else if (clear_overflow) begin
        overflow <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (do_push) mem[wr_ptr] <= wr_entry;
  end

  assign head = (count == '0) ? '{kind: kind_empty, sop: 1'b0, data: 8'h00} : mem[rd_ptr];

endmodule

// File: logic/rx_byte_assembler.sv
// SYNC hunt, LSB-first byte packing and packet framing into tagged FIFO entries
`timescale 1ns/1ps

module rx_byte_assembler import usb_rx_pkg::*; (
  input  logic      clk,
  input  logic      n_rst,
  input  dec_bit_t  dbit,
  output rx_entry_t entry,
  output logic      push
);

  typedef enum logic {
    st_hunt,
    st_data
  } asm_state_t;

  asm_state_t state, state_n;
  logic [7:0] sh, sh_n, sh_next;
  logic [2:0] cnt, cnt_n;
  logic       first, first_n;
  logic       push_n;
  rx_entry_t  entry_n;

  assign sh_next = {dbit.data, sh[7:1]};  // New bit enters at the top

  always_comb begin
    state_n = state;
    sh_n    = sh;
    cnt_n   = cnt;
    first_n = first;
    push_n  = 1'b0;
    entry_n = '{kind: kind_data, sop: first, data: sh_next};
    case (state)
      st_hunt: begin
        if (dbit.valid) begin
          if (sh_next == sync_byte) begin
            state_n = st_data;
            sh_n    = '1;
            cnt_n   = '0;
            first_n = 1'b1;
          end else begin
            sh_n = sh_next;
          end
        end
      end
      st_data: begin
        if (dbit.valid) begin
          sh_n  = sh_next;
          cnt_n = cnt + 1'b1;
          if (cnt == 3'd7) begin
            push_n  = 1'b1;
            first_n = 1'b0;
          end
        end else if (dbit.eop || dbit.err) begin
          push_n       = 1'b1;
          entry_n.kind = (dbit.eop && (cnt == '0)) ? kind_end : kind_err;
          entry_n.sop  = 1'b0;
          entry_n.data = '0;
          state_n      = st_hunt;
          sh_n         = '1;  // No stale bits for the next hunt
        end
      end
      default: state_n = st_hunt;
    endcase
  end

  always_ff @(posedge clk, negedge n_rst) begin
    if (!n_rst) begin
      state <= st_hunt;
      sh    <= '1;
      cnt   <= '0;
      first <= 1'b0;
      push  <= 1'b0;
    end else begin
      state <= state_n;
      sh    <= sh_n;
      cnt   <= cnt_n;
      first <= first_n;
      push  <= push_n;
    end
  end

  always_ff @(posedge clk) begin
    entry <= entry_n;
  end

endmodule

// File: logic/rx_decoder.sv
// NRZI decoder with bit-stuff removal, stuff error and end-of-packet detection
`timescale 1ns/1ps

module rx_decoder import usb_rx_pkg::*; (
  input  logic         clk,
  input  logic         n_rst,
  input  line_sample_t line,
  output dec_bit_t     dbit
);

  logic       is_j;
  logic       is_se0;
  logic       same;
  logic       prev_j;    // Previous non-SE0 level was J
  logic       se0_seen;
  logic [2:0] ones;      // All ones means outside a packet, stuffing not checked

  always_comb begin
    is_j   = line.dp && !line.dm;
    is_se0 = !line.dp && !line.dm;
    same   = (is_j == prev_j);
  end

  always_ff @(posedge clk, negedge n_rst) begin
    if (!n_rst) begin
      prev_j   <= 1'b1;
      se0_seen <= 1'b0;
      ones     <= '1;
      dbit     <= '0;
    end else begin
      dbit <= '0;
      if (line.strobe) begin
        if (is_se0) begin
          se0_seen <= 1'b1;
        end else if (se0_seen) begin
          se0_seen  <= 1'b0;
          prev_j    <= is_j;
          ones      <= '1;
          dbit.eop  <= is_j;
          dbit.err  <= !is_j;  // SE0 then K is not a valid end
        end else begin
          prev_j <= is_j;
          if (ones == stuff_limit) begin
            // Change here is the stuffed zero and is dropped
            ones     <= same ? '1 : '0;
            dbit.err <= same;
          end else begin
            dbit.valid <= 1'b1;
            dbit.data  <= same;
            if (!same) begin
              ones <= '0;
            end else if (ones != '1) begin
              ones <= ones + 1'b1;
            end
          end
        end
      end
    end
  end

endmodule

// File: logic/rx_timer.sv
// Line synchronizer, edge detector and mid-bit sample strobe generator
`timescale 1ns/1ps

module rx_timer import usb_rx_pkg::*; (
  input  logic         clk,
  input  logic         n_rst,
  input  logic         d_plus,
  input  logic         d_minus,
  output line_sample_t line
);

  typedef enum logic [2:0] {
    st_idle,
    st_clear,
    st_wait,
    st_fire,
    st_run
  } timer_state_t;

  timer_state_t state, state_n;

  logic dp_meta, dm_meta;
  logic dp_sync, dm_sync;
  logic dp_last, dm_last;
  logic edge_seen;
  logic clear;
  logic count_enable;
  logic enable_bit;
  logic skip_flag;
  logic bit_flag;

  // Reset to J so an idle line gives no edge
  always_ff @(posedge clk, negedge n_rst) begin
    if (!n_rst) begin
      dp_meta <= 1'b1;
      dm_meta <= 1'b0;
      dp_sync <= 1'b1;
      dm_sync <= 1'b0;
      dp_last <= 1'b1;
      dm_last <= 1'b0;
      state   <= st_idle;
    end else begin
      dp_meta <= d_plus;
      dm_meta <= d_minus;
      dp_sync <= dp_meta;
      dm_sync <= dm_meta;
      dp_last <= dp_sync;
      dm_last <= dm_sync;
      state   <= state_n;
    end
  end

  assign edge_seen = (dp_sync != dp_last) || (dm_sync != dm_last);

  always_comb begin
    state_n = state;
    case (state)
      st_clear: state_n = st_wait;
      st_wait:  state_n = st_fire;
      st_fire:  state_n = st_run;
      default:  state_n = state;
    endcase
    if (edge_seen) begin
      state_n = st_clear;  // Resync on every transition
    end
  end

  assign clear        = (state == st_clear);
  assign count_enable = (state == st_fire) || (state == st_run);
  assign enable_bit   = count_enable && !skip_flag;

  flex_counter #(.num_cnt_bits(6)) stretch_cnt_i (
    .clk          (clk),
    .n_rst        (n_rst),
    .clear        (clear),
    .count_enable (count_enable),
    .rollover_val (stretch_period),
    .rollover_flag(skip_flag)
  );

  flex_counter #(.num_cnt_bits(4)) bit_cnt_i (
    .clk          (clk),
    .n_rst        (n_rst),
    .clear        (clear),
    .count_enable (enable_bit),
    .rollover_val (clks_per_bit),
    .rollover_flag(bit_flag)
  );

  // Strobe only when the bit counter actually wraps, so a stall cannot double it
  assign line.strobe = !edge_seen &&
                       ((state == st_fire) || ((state == st_run) && bit_flag && enable_bit));
  assign line.dp = dp_sync;
  assign line.dm = dm_sync;

endmodule

// File: logic/flex_counter.sv
// Up counter with programmable rollover value, synchronous clear and rollover flag
`timescale 1ns/1ps

module flex_counter #(
  parameter int num_cnt_bits = 4
) (
  input  logic                    clk,
  input  logic                    n_rst,
  input  logic                    clear,
  input  logic                    count_enable,
  input  logic [num_cnt_bits-1:0] rollover_val,
  output logic                    rollover_flag
);

  logic [num_cnt_bits-1:0] count;

  always_ff @(posedge clk, negedge n_rst) begin
    if (!n_rst) begin
      count <= '0;
    end else if (clear) begin
      count <= '0;
    end else if (count_enable) begin
      if (count == rollover_val) begin
        count <= num_cnt_bits'(1);  // Wraps to 1, not 0
      end else begin
        count <= count + 1'b1;
      end
    end
  end

  assign rollover_flag = (count == rollover_val);

endmodule

// File: logic/usb_rx_pkg.sv
// USB full-speed receive path: shared constants, line/bit/entry structs and Wishbone types
package usb_rx_pkg;

  // Timer
  localparam logic [3:0] clks_per_bit   = 4'd8;   // Bit-period counter rollover
  localparam logic [5:0] stretch_period = 6'd25;  // One stall clock per 25, so 3 bits per 25

  // Decoder and assembler
  localparam logic [2:0] stuff_limit = 3'd6;     // Ones before a stuffed zero
  localparam logic [7:0] sync_byte   = 8'h80;    // SYNC after NRZI decode, LSB first

  // FIFO
  localparam int fifo_depth = 16;
  localparam int fifo_aw    = 4;

  // Wishbone word addresses
  localparam logic [1:0] reg_data   = 2'd0;
  localparam logic [1:0] reg_status = 2'd1;

  typedef struct packed {
    logic strobe;  // Mid-bit sample pulse
    logic dp;
    logic dm;
  } line_sample_t;

  typedef struct packed {
    logic valid;
    logic data;
    logic eop;
    logic err;
  } dec_bit_t;

  typedef enum logic [1:0] {
    kind_empty = 2'd0,
    kind_data  = 2'd1,
    kind_end   = 2'd2,
    kind_err   = 2'd3
  } entry_kind_t;

  typedef struct packed {
    entry_kind_t kind;
    logic        sop;
    logic [7:0]  data;
  } rx_entry_t;

  typedef struct packed {
    logic        cyc;
    logic        stb;
    logic        we;
    logic [1:0]  adr;
    logic [31:0] dat;
  } wb_req_t;

  typedef struct packed {
    logic        ack;
    logic [31:0] dat;
  } wb_rsp_t;

endpackage
